// File: Bender.yml
package:
  name: nvram_sync

export_include_dirs:
  - include

sources:
  - hdl/nvram_host_pkg.sv
  - hdl/nvram_core_pkg.sv
  - hdl/nvram_sync_fsm.sv
  - hdl/nvram_addr_counter.sv
  - hdl/nvram_word_lane.sv
  - hdl/nvram_store.sv
  - hdl/nvram_sync_top.sv
  - target: test
    files:
      - dv/nvram_sync_tb.sv

// File: dv/nvram_sync_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "nvram_cfg.svh"

module nvram_sync_tb;
    import nvram_core_pkg::*;
    import nvram_host_pkg::*;

    localparam int WORDS       = `NVRAM_BYTES / 2;
    // Four whole transfers at eight cycles per word, plus slack for CPU sweeps
    localparam int WATCHDOG_NS = (4 * WORDS * 8 + 20000) * 8;
    localparam nvram_addr_t LOCK_ADDR = 13'h0011;

    logic        clk_sys;
    logic        cditop_reset;
    mount_evt_t  mount;
    logic        osd_status;
    logic        host_ack;
    host_rx_t    rx;
    logic        buff_addr_lsb;
    cpu_port_t   cpu;
    host_req_t   host_req;
    host_word_t  tx_word;
    nvram_byte_t cpu_rdata;
    logic        cpu_allow;
    logic        backup_pending;

    integer      seed = 32'h48bd_0634;
    host_word_t  image [WORDS];
    nvram_byte_t shadow [`NVRAM_BYTES];
    logic        shadow_valid [`NVRAM_BYTES];
    host_word_t  taken_words [$];
    int          compared = 0;
    event        word_taken;

    nvram_sync_top DUT (
        .clk_sys        (clk_sys),
        .cditop_reset   (cditop_reset),
        .mount          (mount),
        .osd_status     (osd_status),
        .host_ack       (host_ack),
        .rx             (rx),
        .buff_addr_lsb  (buff_addr_lsb),
        .cpu            (cpu),
        .host_req       (host_req),
        .tx_word        (tx_word),
        .cpu_rdata      (cpu_rdata),
        .cpu_allow      (cpu_allow),
        .backup_pending (backup_pending)
    );

    initial begin
        clk_sys = 1'b0;
        forever #4 clk_sys = ~clk_sys;
    end

    // ========================================
    // Reference model and checks
    // ========================================

    // Image word split little endian, overridden by accepted CPU writes
    function automatic nvram_byte_t expected_byte(input nvram_addr_t a);
        host_word_t w;
        w = image[a[`NVRAM_ADDR_W-1:1]];
        if (shadow_valid[a]) begin
            expected_byte = shadow[a];
        end else begin
            expected_byte = a[0] ? w[15:8] : w[7:0];
        end
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_byte(input nvram_byte_t got, input nvram_byte_t exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("ERR @%0t ns: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_word(input host_word_t got, input host_word_t exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("ERR @%0t ns: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("ERR @%0t ns: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic check_idle(input string when);
        check_flag(host_req.rd, 1'b0, {"read request ", when});
        check_flag(host_req.wr, 1'b0, {"write request ", when});
        check_flag(backup_pending, 1'b0, {"backup_pending ", when});
        check_flag(cpu_allow, 1'b1, {"cpu_allow ", when});
    endtask

    // Backup words are compared as the host model takes them
    initial begin
        host_word_t  w;
        nvram_addr_t lo_addr;
        forever begin
            @(word_taken);
            while (taken_words.size() > 0) begin
                w = taken_words.pop_front();
                lo_addr = nvram_addr_t'(2 * compared);
                check_word(w, {expected_byte(lo_addr + 1'b1), expected_byte(lo_addr)},
                           $sformatf("backup word %0d", compared));
                compared++;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        report_failure("Watchdog expired before the test sequence finished");
    end

    // ========================================
    // Stimulus helpers and host model
    // ========================================

    // Inputs change 1 ns after the rising edge
    task automatic tick();
        @(posedge clk_sys);
        #1;
    endtask

    task automatic apply_reset();
        cditop_reset = 1'b1;
        repeat (8) tick();
        cditop_reset = 1'b0;
        tick();
    endtask

    task automatic mount_image(input logic [63:0] size);
        mount.size   = size;
        mount.change = 1'b1;
        tick();
        mount.change = 1'b0;
    endtask

    // Writes the complement of the current byte so the change is visible
    task automatic write_inverted_byte(input nvram_addr_t a);
        nvram_byte_t d;
        d = ~expected_byte(a);
        shadow[a]       = d;
        shadow_valid[a] = 1'b1;
        cpu.addr = a;
        cpu.data = d;
        cpu.wr   = 1'b1;
        tick();
        cpu.wr = 1'b0;
    endtask

    task automatic wait_for_request(input logic want_rd);
        int n;
        n = 0;
        while (!(want_rd ? host_req.rd : host_req.wr)) begin
            tick();
            n++;
            if (n > 100) begin
                report_failure("The engine raised no host request in 100 cycles");
            end
        end
    endtask

    task automatic run_restore_host();
        wait_for_request(1'b1);
        check_flag(cpu_allow, 1'b0, "cpu_allow at read request");
        repeat (2) tick();
        host_ack = 1'b1;
        repeat (2) tick();
        check_flag(host_req.rd, 1'b0, "read request after ack");
        for (int n = 0; n < WORDS; n++) begin
            rx.word = image[n];
            rx.wr   = 1'b1;
            tick();
            rx.wr = 1'b0;
            repeat (3) tick();
            check_flag(cpu_allow, 1'b0, "cpu_allow during restore");
        end
        tick();
        host_ack = 1'b0;
        tick();
        check_flag(cpu_allow, 1'b1, "cpu_allow after restore");
    endtask

    // Pacing toggle on the buffer address LSB for every word after the first
    task automatic run_backup_host();
        wait_for_request(1'b0);
        repeat (2) tick();
        host_ack = 1'b1;
        for (int n = 0; n < WORDS; n++) begin
            if (n != 0) begin
                buff_addr_lsb = !buff_addr_lsb;
            end
            repeat (4) tick();
            taken_words.push_back(tx_word);
            -> word_taken;
        end
        check_flag(cpu_allow, 1'b0, "cpu_allow during backup");
        host_ack = 1'b0;
        tick();
        check_flag(cpu_allow, 1'b1, "cpu_allow after backup");
    endtask

    // ========================================
    // Test sequence
    // ========================================

    initial begin
        cditop_reset  = 1'b1;
        mount         = '0;
        osd_status    = 1'b0;
        host_ack      = 1'b0;
        rx            = '0;
        buff_addr_lsb = 1'b0;
        cpu           = '0;
        for (int i = 0; i < WORDS; i++) begin
            image[i] = $random(seed);
        end
        for (int i = 0; i < `NVRAM_BYTES; i++) begin
            shadow_valid[i] = 1'b0;
        end
        repeat (8) @(posedge clk_sys);
        #1;
        cditop_reset = 1'b0;
        tick();
        check_idle("after reset");

        // Restore, with a CPU write attempt once its target byte is restored
        mount_image(64'd8192);
        fork
            run_restore_host();
            begin
                repeat (200) tick();
                cpu.addr = LOCK_ADDR;
                cpu.data = ~expected_byte(LOCK_ADDR);
                cpu.wr   = 1'b1;
                tick();
                cpu.wr = 1'b0;
            end
        join
        repeat (2) tick();
        check_flag(backup_pending, 1'b0, "backup_pending after locked write");
        for (int a = 0; a < `NVRAM_BYTES; a++) begin
            cpu.addr = nvram_addr_t'(a);
            tick();
            check_byte(cpu_rdata, expected_byte(nvram_addr_t'(a)), "restored byte");
        end

        // Backup after CPU writes
        write_inverted_byte(13'h0abc);
        write_inverted_byte(13'h1fff);
        repeat (2) tick();
        check_flag(backup_pending, 1'b1, "backup_pending after CPU write");
        osd_status = 1'b1;
        tick();
        check_flag(backup_pending, 1'b0, "backup_pending once backup starts");
        run_backup_host();
        osd_status = 1'b0;
        check_flag(backup_pending, 1'b0, "backup_pending after backup");

        // Reset clears the pending flag but keeps the mount
        write_inverted_byte(13'h0042);
        repeat (2) tick();
        check_flag(backup_pending, 1'b1, "backup_pending before reset");
        apply_reset();
        check_idle("after reset with pending set");
        write_inverted_byte(13'h0043);
        repeat (2) tick();
        check_flag(backup_pending, 1'b1, "backup_pending after reset while mounted");
        apply_reset();

        // Empty mount
        mount_image(64'd0);
        repeat (2) tick();
        check_idle("after empty mount");
        write_inverted_byte(13'h0044);
        repeat (2) tick();
        check_flag(backup_pending, 1'b0, "backup_pending with no image");
        cpu.addr = 13'h0044;
        tick();
        check_byte(cpu_rdata, expected_byte(13'h0044), "CPU write with no image");

        if (compared != WORDS) begin
            report_failure($sformatf("Backup delivered %0d words instead of %0d",
                                     compared, WORDS));
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+include
hdl/nvram_host_pkg.sv
hdl/nvram_core_pkg.sv
hdl/nvram_sync_fsm.sv
hdl/nvram_addr_counter.sv
hdl/nvram_word_lane.sv
hdl/nvram_store.sv
hdl/nvram_sync_top.sv
dv/nvram_sync_tb.sv

// File: hdl/nvram_addr_counter.sv
`timescale 1ns/1ns
`default_nettype none

module nvram_addr_counter (
    input  wire logic                     clk_sys,
    input  wire logic                     cditop_reset,
    input  wire nvram_core_pkg::cnt_ctl_t cnt_ctl,
    input  wire logic                     buff_addr_lsb,
    output nvram_core_pkg::nvram_addr_t   addr,
    output logic                          host_step
);

    // Previous host buffer address bit
    logic lsb_q;

    // ========================================
    // Store byte address
    // ========================================

    always_ff @(posedge clk_sys) begin
        if (cditop_reset || cnt_ctl.clear) begin
            addr <= '0;
        end else if (cnt_ctl.step) begin
            addr <= addr + 1'b1;
        end
    end

    // ========================================
    // Host pacing
    // ========================================

    always_ff @(posedge clk_sys) begin
        lsb_q <= buff_addr_lsb;
    end

    // One cycle pulse per toggle of the buffer address
    assign host_step = (lsb_q != buff_addr_lsb);

    a_clear_step: assert property (
        @(posedge clk_sys) disable iff (cditop_reset)
        cnt_ctl.clear |-> !cnt_ctl.step
    ) else $error("address clear and step at the same time");

endmodule

`default_nettype wire

// File: hdl/nvram_core_pkg.sv
`default_nettype none

`include "nvram_cfg.svh"

package nvram_core_pkg;

    // ========================================
    // Engine sequencing
    // ========================================

    typedef enum logic [3:0] {
        IDLE,
        WAIT_FOR_ACK,
        BACKUP0,
        BACKUP1,
        BACKUP2,
        BACKUP3,
        RESTORE0,
        RESTORE1,
        RESTORE2
    } nvram_state_e;

    // ========================================
    // Store and CPU port
    // ========================================

    typedef logic [`NVRAM_ADDR_W-1:0] nvram_addr_t;
    typedef logic [7:0]               nvram_byte_t;

    typedef struct packed {
        logic        wr;
        nvram_addr_t addr;
        nvram_byte_t data;
    } cpu_port_t;

    // Strobes toward the word lane
    typedef struct packed {
        logic capture_lo;
        logic capture_hi;
        logic latch_restore;
    } lane_ctl_t;

    // Strobes toward the address counter
    typedef struct packed {
        logic clear;
        logic step;
    } cnt_ctl_t;

endpackage

`default_nettype wire

// File: hdl/nvram_host_pkg.sv
`default_nettype none

`include "nvram_cfg.svh"

package nvram_host_pkg;

    // ========================================
    // Host block device side
    // ========================================

    // One word of the host sector buffer
    typedef logic [`HOST_WORD_W-1:0] host_word_t;

    // Transfer requests toward the host
    typedef struct packed {
        logic rd;
        logic wr;
    } host_req_t;

    // Buffer data coming from the host during a restore
    typedef struct packed {
        logic       wr;
        host_word_t word;
    } host_rx_t;

    // Image mount event from the host
    // A zero size means the image was removed
    typedef struct packed {
        logic        change;
        logic [63:0] size;
    } mount_evt_t;

endpackage

`default_nettype wire

// File: hdl/nvram_store.sv
`timescale 1ns/1ns
`default_nettype none

`include "nvram_cfg.svh"

module nvram_store (
    input  wire logic                        clk_sys,
    input  wire nvram_core_pkg::cpu_port_t   cpu,
    input  wire logic                        cpu_allow,
    input  wire nvram_core_pkg::nvram_addr_t eng_addr,
    input  wire logic                        eng_wr,
    input  wire nvram_core_pkg::nvram_byte_t eng_wdata,
    output nvram_core_pkg::nvram_byte_t      cpu_rdata,
    output nvram_core_pkg::nvram_byte_t      eng_rdata,
    output logic                             cpu_changed
);
    import nvram_core_pkg::*;

    nvram_byte_t mem [`NVRAM_BYTES];

    logic cpu_wr_ok;

    // CPU writes are dropped while the engine owns the store
    assign cpu_wr_ok = cpu.wr && cpu_allow;

    // ========================================
    // Shared write port
    // ========================================

    // Engine and CPU never write in the same cycle
    always_ff @(posedge clk_sys) begin
        if (eng_wr) begin
            mem[eng_addr] <= eng_wdata;
        end else if (cpu_wr_ok) begin
            mem[cpu.addr] <= cpu.data;
        end
    end

    // ========================================
    // Read ports
    // ========================================

    always_ff @(posedge clk_sys) begin
        cpu_rdata   <= mem[cpu.addr];
        eng_rdata   <= mem[eng_addr];
        cpu_changed <= cpu_wr_ok;
    end

    a_engine_owns: assert property (
        @(posedge clk_sys) eng_wr |-> !cpu_allow
    ) else $error("engine write while CPU access is open");

endmodule

`default_nettype wire

// File: hdl/nvram_sync_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module nvram_sync_fsm (
    input  wire logic                       clk_sys,
    input  wire logic                       cditop_reset,
    input  wire nvram_host_pkg::mount_evt_t mount,
    input  wire logic                       osd_status,
    input  wire logic                       host_ack,
    input  wire logic                       host_step,
    input  wire logic                       rx_wr,
    input  wire logic                       cpu_changed,
    output nvram_host_pkg::host_req_t       host_req,
    output nvram_core_pkg::cnt_ctl_t        cnt_ctl,
    output nvram_core_pkg::lane_ctl_t       lane_ctl,
    output logic                            eng_wr,
    output logic                            cpu_allow,
    output logic                            backup_pending
);
    import nvram_core_pkg::*;

    nvram_state_e state;

    // Set while a usable image is mounted
    logic mounted = 1'b0;
    logic osd_q;

    logic img_mount;
    logic osd_rise;
    logic start_restore;
    logic start_backup;

    assign img_mount = mount.change && (mount.size != '0);
    assign osd_rise  = osd_status && !osd_q;

    // A fresh image always wins over a pending backup
    assign start_restore = (state == IDLE) && img_mount;
    assign start_backup  = (state == IDLE) && !img_mount && backup_pending && osd_rise;

    // ========================================
    // Mount tracking and backup request
    // ========================================

    always_ff @(posedge clk_sys) begin
        osd_q <= osd_status;
        if (mount.change) begin
            mounted <= (mount.size != '0);
        end
    end

    // Cleared when a backup starts so later CPU writes request another one
    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            backup_pending <= 1'b0;
        end else if (start_backup) begin
            backup_pending <= 1'b0;
        end else if (cpu_changed && mounted) begin
            backup_pending <= 1'b1;
        end
    end

    // ========================================
    // Transfer sequencing
    // ========================================

    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            state    <= IDLE;
            host_req <= '0;
        end else begin
            if (host_ack) begin
                host_req <= '0;
            end

            case (state)
                IDLE: begin
                    if (start_restore) begin
                        host_req.rd <= 1'b1;
                        state       <= WAIT_FOR_ACK;
                    end else if (start_backup) begin
                        host_req.wr <= 1'b1;
                        state       <= WAIT_FOR_ACK;
                    end
                end
                WAIT_FOR_ACK: begin
                    if (host_ack && host_req.rd) begin
                        state <= RESTORE0;
                    end else if (host_ack && host_req.wr) begin
                        state <= BACKUP0;
                    end
                end
                BACKUP0: state <= BACKUP1;
                BACKUP1: state <= BACKUP2;
                BACKUP2: state <= BACKUP3;
                BACKUP3: begin
                    // Host asks for the next word
                    if (host_step) begin
                        state <= BACKUP1;
                    end
                    if (!host_ack) begin
                        state <= IDLE;
                    end
                end
                RESTORE0: begin
                    if (rx_wr) begin
                        state <= RESTORE1;
                    end
                    if (!host_ack) begin
                        state <= IDLE;
                    end
                end
                RESTORE1: state <= RESTORE2;
                RESTORE2: state <= RESTORE0;
                default:  state <= IDLE;
            endcase
        end
    end

    // Address stays at zero in IDLE so every transfer starts at byte 0
    assign cnt_ctl.clear = (state == IDLE);
    assign cnt_ctl.step  = (state inside {BACKUP0, BACKUP1, RESTORE1, RESTORE2}) ||
                           ((state == BACKUP3) && host_step);

    // Read data lags the address by one cycle
    assign lane_ctl.capture_lo    = (state == BACKUP1);
    assign lane_ctl.capture_hi    = (state == BACKUP2);
    assign lane_ctl.latch_restore = (state == RESTORE0) && rx_wr;

    // Low byte in RESTORE1, high byte in RESTORE2
    assign eng_wr    = (state == RESTORE1) || (state == RESTORE2);
    assign cpu_allow = (state == IDLE);

    a_one_request: assert property (
        @(posedge clk_sys) disable iff (cditop_reset)
        host_req.rd |-> !host_req.wr
    ) else $error("read and write requested together");

endmodule

`default_nettype wire

// File: hdl/nvram_sync_top.sv
`timescale 1ns/1ns
`default_nettype none

module nvram_sync_top (
    input  wire logic                       clk_sys,
    input  wire logic                       cditop_reset,
    input  wire nvram_host_pkg::mount_evt_t mount,
    input  wire logic                       osd_status,
    input  wire logic                       host_ack,
    input  wire nvram_host_pkg::host_rx_t   rx,
    input  wire logic                       buff_addr_lsb,
    input  wire nvram_core_pkg::cpu_port_t  cpu,
    output nvram_host_pkg::host_req_t       host_req,
    output nvram_host_pkg::host_word_t      tx_word,
    output nvram_core_pkg::nvram_byte_t     cpu_rdata,
    output logic                            cpu_allow,
    output logic                            backup_pending
);
    import nvram_core_pkg::*;

    cnt_ctl_t    cnt_ctl;
    lane_ctl_t   lane_ctl;
    nvram_addr_t eng_addr;
    nvram_byte_t eng_wdata;
    nvram_byte_t eng_rdata;
    logic        eng_wr;
    logic        host_step;
    logic        cpu_changed;

    // ========================================
    // Engine
    // ========================================

    nvram_sync_fsm u_fsm (
        .clk_sys        (clk_sys),
        .cditop_reset   (cditop_reset),
        .mount          (mount),
        .osd_status     (osd_status),
        .host_ack       (host_ack),
        .host_step      (host_step),
        .rx_wr          (rx.wr),
        .cpu_changed    (cpu_changed),
        .host_req       (host_req),
        .cnt_ctl        (cnt_ctl),
        .lane_ctl       (lane_ctl),
        .eng_wr         (eng_wr),
        .cpu_allow      (cpu_allow),
        .backup_pending (backup_pending)
    );

    nvram_addr_counter u_counter (
        .clk_sys       (clk_sys),
        .cditop_reset  (cditop_reset),
        .cnt_ctl       (cnt_ctl),
        .buff_addr_lsb (buff_addr_lsb),
        .addr          (eng_addr),
        .host_step     (host_step)
    );

    // Even addresses take the low half of a host word
    nvram_word_lane u_lane (
        .clk_sys   (clk_sys),
        .lane_ctl  (lane_ctl),
        .rx        (rx),
        .addr_lsb  (eng_addr[0]),
        .eng_rdata (eng_rdata),
        .wdata     (eng_wdata),
        .tx_word   (tx_word)
    );

    // ========================================
    // Store
    // ========================================

    nvram_store u_store (
        .clk_sys     (clk_sys),
        .cpu         (cpu),
        .cpu_allow   (cpu_allow),
        .eng_addr    (eng_addr),
        .eng_wr      (eng_wr),
        .eng_wdata   (eng_wdata),
        .cpu_rdata   (cpu_rdata),
        .eng_rdata   (eng_rdata),
        .cpu_changed (cpu_changed)
    );

endmodule

`default_nettype wire

// File: hdl/nvram_word_lane.sv
`timescale 1ns/1ns
`default_nettype none

module nvram_word_lane (
    input  wire logic                        clk_sys,
    input  wire nvram_core_pkg::lane_ctl_t   lane_ctl,
    input  wire nvram_host_pkg::host_rx_t    rx,
    input  wire logic                        addr_lsb,
    input  wire nvram_core_pkg::nvram_byte_t eng_rdata,
    output nvram_core_pkg::nvram_byte_t      wdata,
    output nvram_host_pkg::host_word_t       tx_word
);
    import nvram_host_pkg::*;

    // Last word received from the host
    host_word_t rx_word;

    // ========================================
    // Restore path
    // ========================================

    always_ff @(posedge clk_sys) begin
        if (lane_ctl.latch_restore) begin
            rx_word <= rx.word;
        end
    end

    // Host words are little endian so the even byte sits in the low half
    assign wdata = addr_lsb ? rx_word[15:8] : rx_word[7:0];

    // ========================================
    // Backup path
    // ========================================

    always_ff @(posedge clk_sys) begin
        if (lane_ctl.capture_lo) begin
            tx_word[7:0] <= eng_rdata;
        end
        if (lane_ctl.capture_hi) begin
            tx_word[15:8] <= eng_rdata;
        end
    end

endmodule

`default_nettype wire

// File: include/nvram_cfg.svh
`ifndef NVRAM_CFG_SVH
`define NVRAM_CFG_SVH

// ========================================
// NvRAM store geometry
// ========================================

// Depth of the byte-wide store
`define NVRAM_BYTES 8192

// Byte address width, log2 of the depth
`define NVRAM_ADDR_W 13

// ========================================
// Host block device
// ========================================

// Width of one host buffer word
`define HOST_WORD_W 16

`endif
